/* core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ==============================
// datapath widths
// ==============================

// data and address width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

// ==============================
// memory sizes
// ==============================

// instruction memory word address bits
`define IMEM_DEPTH_LOG2 6

// data memory word address bits
`define DMEM_DEPTH_LOG2 6

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

`endif

/* core_pkg.sv */
`include "core_settings.svh"

package core_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011
  } opcode_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA
  } alu_op_e;

  typedef struct packed {
    logic    reg_write;
    logic    mem_read;
    logic    mem_write;
    logic    use_imm;
    logic    is_lui;
    alu_op_e alu_op;
  } ctrl_t;

  // ==============================
  // stage payloads
  // ==============================

  typedef struct packed {
    logic                   valid;
    ctrl_t                  ctrl;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    logic [`XLEN-1:0]       imm;
  } id_ex_t;

  typedef struct packed {
    logic                   valid;
    logic                   reg_write;
    logic                   mem_read;
    logic                   mem_write;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       alu_result;
    logic [`XLEN-1:0]       store_data;
  } ex_mem_t;

  typedef struct packed {
    logic                   valid;
    logic                   reg_write;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       result;
  } mem_wb_t;

  // forward source into execute
  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } fwd_t;

  typedef struct packed {
    logic                   valid;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } retire_t;

  typedef struct packed {
    logic                       we;
    logic [`IMEM_DEPTH_LOG2-1:0] addr;
    logic [`XLEN-1:0]           inst;
  } prog_wr_t;

endpackage

/* pipe_reg.sv */
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n_i,
  input  logic     en_i,
  input  logic     bubble_i,
  input  payload_t d_i,
  output payload_t q_o
);

  // all-zero payload carries valid low
  always_ff @(posedge clk) begin
    if (!rst_n_i || bubble_i) begin
      q_o <= '0;
    end else if (en_i) begin
      q_o <= d_i;
    end
  end

endmodule

/* fetch_unit.sv */
`include "core_settings.svh"

module fetch_unit (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               run_i,
  input  logic               stall_i,
  input  core_pkg::prog_wr_t prog_i,
  output logic [`XLEN-1:0]   inst_o,
  output logic               inst_valid_o
);

  localparam int IMEM_WORDS = 2 ** `IMEM_DEPTH_LOG2;

  logic [`XLEN-1:0]          imem [IMEM_WORDS];
  // word index, top bit set once fetch runs past the end
  logic [`IMEM_DEPTH_LOG2:0] pc;
  logic                      pc_done;
  logic                      fetch_en;
  logic [`XLEN-1:0]          inst_q;
  logic                      inst_valid_q;

  assign pc_done  = pc[`IMEM_DEPTH_LOG2];
  assign fetch_en = run_i && !stall_i;

  // ==============================
  // pc and slot valid
  // ==============================
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      pc           <= '0;
      inst_valid_q <= 1'b0;
    end else if (fetch_en) begin
      inst_valid_q <= !pc_done;
      if (!pc_done) begin
        pc <= pc + 1'b1;
      end
    end else if (!stall_i) begin
      // not running, slot drains
      inst_valid_q <= 1'b0;
    end
  end

  // program load port and synchronous read
  always_ff @(posedge clk) begin
    if (prog_i.we) begin
      imem[prog_i.addr] <= prog_i.inst;
    end
    if (fetch_en) begin
      inst_q <= imem[pc[`IMEM_DEPTH_LOG2-1:0]];
    end
  end

  assign inst_o       = inst_valid_q ? inst_q : `NOP_INST;
  assign inst_valid_o = inst_valid_q;

endmodule

/* decode_unit.sv */
`include "core_settings.svh"

module decode_unit (
  input  logic                   clk,
  input  logic                   rst_n_i,
  input  logic [`XLEN-1:0]       inst_i,
  input  logic                   inst_valid_i,
  input  logic [`REG_ADDR_W-1:0] ex_rd_i,
  input  logic                   ex_mem_read_i,
  input  core_pkg::mem_wb_t      wb_i,
  output core_pkg::id_ex_t       id_ex_o,
  output logic                   stall_o
);

  localparam int NUM_REGS = 2 ** `REG_ADDR_W;

  core_pkg::opcode_e      opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [`REG_ADDR_W-1:0] rs1_f;
  logic [`REG_ADDR_W-1:0] rs2_f;
  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`XLEN-1:0]       imm_i;
  logic [`XLEN-1:0]       imm_s;
  logic [`XLEN-1:0]       imm_u;
  logic [`XLEN-1:0]       imm;
  core_pkg::ctrl_t        ctrl;
  logic                   known;
  logic                   use_rs1;
  logic                   use_rs2;
  logic                   dec_valid;
  logic [`XLEN-1:0]       regs [NUM_REGS];
  logic                   wb_we;
  logic [`XLEN-1:0]       rs1_data;
  logic [`XLEN-1:0]       rs2_data;

  function automatic core_pkg::alu_op_e alu_decode(input logic [2:0] f3, input logic alt);
    core_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
      3'b001:  op = core_pkg::ALU_SLL;
      3'b010:  op = core_pkg::ALU_SLT;
      3'b011:  op = core_pkg::ALU_SLTU;
      3'b100:  op = core_pkg::ALU_XOR;
      3'b101:  op = alt ? core_pkg::ALU_SRA : core_pkg::ALU_SRL;
      3'b110:  op = core_pkg::ALU_OR;
      default: op = core_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // ==============================
  // fields and immediates
  // ==============================
  assign opcode = core_pkg::opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];
  assign rs1_f  = inst_i[19:15];
  assign rs2_f  = inst_i[24:20];
  assign imm_i  = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s  = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_u  = {inst_i[31:12], 12'b0};

  always_comb begin
    ctrl    = '0;
    known   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    imm     = imm_i;
    case (opcode)
      core_pkg::OPC_OP: begin
        known = (funct7 == 7'b0000000) ||
                (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, funct7[5]);
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      core_pkg::OPC_OP_IMM: begin
        // no subi, so only the right shift reads the alt bit
        if (funct3 == 3'b001) begin
          known = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          known = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end else begin
          known = 1'b1;
        end
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.alu_op    = alu_decode(funct3, (funct3 == 3'b101) && funct7[5]);
        use_rs1        = 1'b1;
      end
      core_pkg::OPC_LUI: begin
        known          = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        ctrl.is_lui    = 1'b1;
        imm            = imm_u;
      end
      core_pkg::OPC_LOAD: begin
        known          = (funct3 == 3'b010);
        ctrl.reg_write = 1'b1;
        ctrl.mem_read  = 1'b1;
        ctrl.use_imm   = 1'b1;
        use_rs1        = 1'b1;
      end
      core_pkg::OPC_STORE: begin
        known          = (funct3 == 3'b010);
        ctrl.mem_write = 1'b1;
        ctrl.use_imm   = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
        imm            = imm_s;
      end
      default: begin
        known = 1'b0;
      end
    endcase
  end

  assign dec_valid = inst_valid_i && known;
  assign rs1       = use_rs1 ? rs1_f : '0;
  assign rs2       = use_rs2 ? rs2_f : '0;

  // ==============================
  // register file
  // ==============================
  assign wb_we = wb_i.valid && wb_i.reg_write && (wb_i.rd != '0);

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_we) begin
      regs[wb_i.rd] <= wb_i.result;
    end
  end

  // x0 reads zero, writeback value bypasses the array
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wb_we && wb_i.rd == rs1) ? wb_i.result : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb_we && wb_i.rd == rs2) ? wb_i.result : regs[rs2];

  // load in execute feeding a source here costs one bubble
  assign stall_o = dec_valid && ex_mem_read_i && (ex_rd_i != '0) &&
                   ((use_rs1 && rs1 == ex_rd_i) || (use_rs2 && rs2 == ex_rd_i));

  always_comb begin
    id_ex_o.valid    = dec_valid;
    id_ex_o.ctrl     = dec_valid ? ctrl : '0;
    id_ex_o.rs1      = rs1;
    id_ex_o.rs2      = rs2;
    id_ex_o.rd       = ctrl.reg_write ? inst_i[11:7] : '0;
    id_ex_o.rs1_data = rs1_data;
    id_ex_o.rs2_data = rs2_data;
    id_ex_o.imm      = imm;
  end

endmodule

/* execute_unit.sv */
`include "core_settings.svh"

module execute_unit (
  input  core_pkg::id_ex_t  id_ex_i,
  input  core_pkg::fwd_t    mem_fwd_i,
  input  core_pkg::fwd_t    wb_fwd_i,
  output core_pkg::ex_mem_t ex_mem_o
);

  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] op_a;
  logic [`XLEN-1:0] op_b;
  logic [4:0]       shamt;
  logic [`XLEN-1:0] alu_result;

  // newest producer wins, x0 is never forwarded
  function automatic logic [`XLEN-1:0] fwd_sel(
    input logic [`REG_ADDR_W-1:0] rs,
    input logic [`XLEN-1:0]       reg_val,
    input core_pkg::fwd_t         mem_fwd,
    input core_pkg::fwd_t         wb_fwd
  );
    logic [`XLEN-1:0] val;
    if (rs != '0 && mem_fwd.valid && mem_fwd.rd == rs) begin
      val = mem_fwd.data;
    end else if (rs != '0 && wb_fwd.valid && wb_fwd.rd == rs) begin
      val = wb_fwd.data;
    end else begin
      val = reg_val;
    end
    return val;
  endfunction

  // ==============================
  // operands
  // ==============================
  assign rs1_val = fwd_sel(id_ex_i.rs1, id_ex_i.rs1_data, mem_fwd_i, wb_fwd_i);
  assign rs2_val = fwd_sel(id_ex_i.rs2, id_ex_i.rs2_data, mem_fwd_i, wb_fwd_i);
  assign op_a    = rs1_val;
  assign op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_val;
  assign shamt   = op_b[4:0];

  // ==============================
  // alu
  // ==============================
  always_comb begin
    if (id_ex_i.ctrl.is_lui) begin
      alu_result = id_ex_i.imm;
    end else begin
      case (id_ex_i.ctrl.alu_op)
        core_pkg::ALU_ADD:  alu_result = op_a + op_b;
        core_pkg::ALU_SUB:  alu_result = op_a - op_b;
        core_pkg::ALU_AND:  alu_result = op_a & op_b;
        core_pkg::ALU_OR:   alu_result = op_a | op_b;
        core_pkg::ALU_XOR:  alu_result = op_a ^ op_b;
        core_pkg::ALU_SLT:  alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
        core_pkg::ALU_SLTU: alu_result = {31'b0, op_a < op_b};
        core_pkg::ALU_SLL:  alu_result = op_a << shamt;
        core_pkg::ALU_SRL:  alu_result = op_a >> shamt;
        core_pkg::ALU_SRA:  alu_result = $signed(op_a) >>> shamt;
        default:            alu_result = op_a + op_b;
      endcase
    end
  end

  always_comb begin
    ex_mem_o.valid      = id_ex_i.valid;
    ex_mem_o.reg_write  = id_ex_i.ctrl.reg_write;
    ex_mem_o.mem_read   = id_ex_i.ctrl.mem_read;
    ex_mem_o.mem_write  = id_ex_i.ctrl.mem_write;
    ex_mem_o.rd         = id_ex_i.rd;
    ex_mem_o.alu_result = alu_result;
    // store data uses the forwarded rs2
    ex_mem_o.store_data = rs2_val;
  end

endmodule

/* mem_wb_unit.sv */
`include "core_settings.svh"

module mem_wb_unit (
  input  logic              clk,
  input  logic              rst_n_i,
  input  core_pkg::ex_mem_t ex_mem_i,
  output core_pkg::fwd_t    mem_fwd_o,
  output core_pkg::mem_wb_t mem_wb_o,
  output core_pkg::retire_t retire_o
);

  localparam int DMEM_WORDS = 2 ** `DMEM_DEPTH_LOG2;

  logic [`XLEN-1:0]            dmem [DMEM_WORDS];
  logic [`DMEM_DEPTH_LOG2-1:0] word_addr;
  logic [`XLEN-1:0]            load_data;
  logic [`XLEN-1:0]            result;

  // ==============================
  // data memory
  // ==============================
  assign word_addr = ex_mem_i.alu_result[`DMEM_DEPTH_LOG2+1:2];

  always_ff @(posedge clk) begin
    if (ex_mem_i.valid && ex_mem_i.mem_write) begin
      dmem[word_addr] <= ex_mem_i.store_data;
    end
  end

  assign load_data = dmem[word_addr];
  assign result    = ex_mem_i.mem_read ? load_data : ex_mem_i.alu_result;

  // load data is too late to forward from here
  always_comb begin
    mem_fwd_o.valid = ex_mem_i.valid && ex_mem_i.reg_write && !ex_mem_i.mem_read;
    mem_fwd_o.rd    = ex_mem_i.rd;
    mem_fwd_o.data  = ex_mem_i.alu_result;
  end

  always_comb begin
    mem_wb_o.valid     = ex_mem_i.valid;
    mem_wb_o.reg_write = ex_mem_i.reg_write;
    mem_wb_o.rd        = ex_mem_i.rd;
    mem_wb_o.result    = result;
  end

  // retire report, same cycle as the writeback register
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      retire_o <= '0;
    end else begin
      retire_o.valid <= mem_wb_o.valid && mem_wb_o.reg_write && (mem_wb_o.rd != '0);
      retire_o.rd    <= mem_wb_o.rd;
      retire_o.data  <= mem_wb_o.result;
    end
  end

endmodule

/* core_top.sv */
`include "core_settings.svh"

module core_top (
  input  logic               clk,
  input  logic               rst_n_i,
  input  logic               run_i,
  input  core_pkg::prog_wr_t prog_i,
  output core_pkg::retire_t  retire_o
);

  logic [`XLEN-1:0]  inst;
  logic              inst_valid;
  logic              stall;
  core_pkg::id_ex_t  id_ex_d;
  core_pkg::id_ex_t  id_ex_q;
  core_pkg::ex_mem_t ex_mem_d;
  core_pkg::ex_mem_t ex_mem_q;
  core_pkg::mem_wb_t mem_wb_d;
  core_pkg::mem_wb_t mem_wb_q;
  core_pkg::fwd_t    mem_fwd;
  core_pkg::fwd_t    wb_fwd;

  // ==============================
  // fetch and decode
  // ==============================
  fetch_unit fetch_unit_inst (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .run_i        (run_i),
    .stall_i      (stall),
    .prog_i       (prog_i),
    .inst_o       (inst),
    .inst_valid_o (inst_valid)
  );

  decode_unit decode_unit_inst (
    .clk           (clk),
    .rst_n_i       (rst_n_i),
    .inst_i        (inst),
    .inst_valid_i  (inst_valid),
    .ex_rd_i       (id_ex_q.rd),
    .ex_mem_read_i (id_ex_q.ctrl.mem_read),
    .wb_i          (mem_wb_q),
    .id_ex_o       (id_ex_d),
    .stall_o       (stall)
  );

  // stall turns the decode slot into a bubble
  pipe_reg #(.payload_t(core_pkg::id_ex_t)) id_ex_reg (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .en_i     (!stall),
    .bubble_i (stall),
    .d_i      (id_ex_d),
    .q_o      (id_ex_q)
  );

  // ==============================
  // execute, memory, writeback
  // ==============================
  execute_unit execute_unit_inst (
    .id_ex_i   (id_ex_q),
    .mem_fwd_i (mem_fwd),
    .wb_fwd_i  (wb_fwd),
    .ex_mem_o  (ex_mem_d)
  );

  pipe_reg #(.payload_t(core_pkg::ex_mem_t)) ex_mem_reg (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .en_i     (1'b1),
    .bubble_i (1'b0),
    .d_i      (ex_mem_d),
    .q_o      (ex_mem_q)
  );

  mem_wb_unit mem_wb_unit_inst (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .ex_mem_i  (ex_mem_q),
    .mem_fwd_o (mem_fwd),
    .mem_wb_o  (mem_wb_d),
    .retire_o  (retire_o)
  );

  pipe_reg #(.payload_t(core_pkg::mem_wb_t)) mem_wb_reg (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .en_i     (1'b1),
    .bubble_i (1'b0),
    .d_i      (mem_wb_d),
    .q_o      (mem_wb_q)
  );

  always_comb begin
    wb_fwd.valid = mem_wb_q.valid && mem_wb_q.reg_write;
    wb_fwd.rd    = mem_wb_q.rd;
    wb_fwd.data  = mem_wb_q.result;
  end

endmodule

/* core_assert.sv */
module core_assert (
  input logic              clk,
  input logic              rst_n_i,
  input logic              stall_i,
  input core_pkg::retire_t retire_i
);
  timeunit 1ns;
  timeprecision 100ps;

  // synchronous reset clears the retire report on the following edge
  retire_low_after_reset: assert property (
    @(posedge clk) !rst_n_i |=> !retire_i.valid
  ) else $error("retire report valid in the cycle after reset");

  retire_rd_nonzero: assert property (
    @(posedge clk) disable iff (!rst_n_i) retire_i.valid |-> retire_i.rd != '0
  ) else $error("retire report names register x0");

  // one bubble per load-use pair
  stall_single_cycle: assert property (
    @(posedge clk) disable iff (!rst_n_i) stall_i |=> !stall_i
  ) else $error("decode stall held for two cycles in a row");

endmodule

bind core_top core_assert core_assert_inst (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .stall_i  (stall),
  .retire_i (retire_o)
);

/* core_tb.sv */
`include "core_settings.svh"

module core_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PROG_LEN     = 2 ** `IMEM_DEPTH_LOG2;
  localparam int SEED_LEN     = 4;
  localparam int DMEM_WORDS   = 2 ** `DMEM_DEPTH_LOG2;
  localparam int NUM_TESTS    = 5;
  localparam int RESET_CYCLES = 3;
  localparam int DRAIN_CYCLES = 8;
  localparam int CYCLE_LIMIT  = 2 * PROG_LEN + 40;

  localparam logic [2:0] K_REG   = 3'd0;
  localparam logic [2:0] K_IMM   = 3'd1;
  localparam logic [2:0] K_LUI   = 3'd2;
  localparam logic [2:0] K_LOAD  = 3'd3;
  localparam logic [2:0] K_STORE = 3'd4;

  // abstract instruction, encoded only when written to the DUT
  typedef struct packed {
    logic [2:0]             kind;
    core_pkg::alu_op_e      alu;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       imm;
  } instr_t;

  typedef struct packed {
    logic [`REG_ADDR_W-1:0] rd;
    logic [`XLEN-1:0]       data;
  } exp_t;

  logic               clk = 1'b0;
  logic               rst_n_i;
  logic               run_i;
  core_pkg::prog_wr_t prog_i;
  core_pkg::retire_t  retire_o;

  integer           seed;
  instr_t           prog [PROG_LEN];
  logic [`XLEN-1:0] mregs [32];
  logic [`XLEN-1:0] mdmem [DMEM_WORDS];
  logic             written [DMEM_WORDS];
  int               last_word;
  exp_t             exp_q [$];
  int               cur_test;
  int               mismatch_count;
  int               other_count;
  int               run_cycles;
  logic             timed_out;

  core_top core_top_inst (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .run_i    (run_i),
    .prog_i   (prog_i),
    .retire_o (retire_o)
  );

  always #2 clk = ~clk;

  // ==============================
  // random program generation
  // ==============================
  function automatic string test_name(input int t);
    case (t)
      0:       return "alu_fwd";
      1:       return "imm_ops";
      2:       return "load_use";
      3:       return "x0_writes";
      default: return "random";
    endcase
  endfunction

  function automatic int rand_below(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic int rand_reg();
    return 1 + rand_below(8);
  endfunction

  function automatic int x0_or_reg();
    return (rand_below(2) == 0) ? 0 : rand_reg();
  endfunction

  function automatic logic [31:0] rand_imm12();
    logic [31:0] r;
    r = $random(seed);
    return {{20{r[11]}}, r[11:0]};
  endfunction

  function automatic logic [31:0] rand_upper();
    logic [31:0] r;
    r = $random(seed);
    return {r[31:12], 12'b0};
  endfunction

  function automatic instr_t make_instr(input logic [2:0] kind, input core_pkg::alu_op_e alu,
                                        input int rd, input int rs1, input int rs2,
                                        input logic [31:0] imm);
    instr_t ins;
    ins.kind = kind;
    ins.alu  = alu;
    ins.rd   = 5'(rd);
    ins.rs1  = 5'(rs1);
    ins.rs2  = 5'(rs2);
    ins.imm  = imm;
    return ins;
  endfunction

  function automatic instr_t random_alu_instr(input int rd, input int rs1, input int rs2,
                                              input logic use_imm);
    core_pkg::alu_op_e alu;
    int                a;
    logic [31:0]       imm;
    instr_t            ins;
    if (use_imm) begin
      // any operation but sub
      a   = rand_below(9);
      alu = core_pkg::alu_op_e'((a == 0) ? 0 : a + 1);
      if (alu inside {core_pkg::ALU_SLL, core_pkg::ALU_SRL, core_pkg::ALU_SRA}) begin
        imm = 32'(rand_below(32));
      end else begin
        imm = rand_imm12();
      end
      ins = make_instr(K_IMM, alu, rd, rs1, 0, imm);
    end else begin
      alu = core_pkg::alu_op_e'(rand_below(10));
      ins = make_instr(K_REG, alu, rd, rs1, rs2, '0);
    end
    return ins;
  endfunction

  // memory accesses use x0 as base, so the word is known here
  function automatic instr_t mem_instr(input logic [2:0] kind, input int r, input int word);
    if (kind == K_STORE) begin
      written[word] = 1'b1;
      last_word     = word;
      return make_instr(K_STORE, core_pkg::ALU_ADD, 0, 0, r, 32'(word * 4));
    end
    return make_instr(K_LOAD, core_pkg::ALU_ADD, r, 0, 0, 32'(word * 4));
  endfunction

  function automatic void generate_program(input int mode);
    int last_rd;
    int prev_rd;
    int load_rd;
    int word;
    int k;
    int i;
    last_rd = 4;
    prev_rd = 1;
    load_rd = 1;
    word    = 0;
    prog[0] = make_instr(K_LUI, core_pkg::ALU_ADD, 1, 0, 0, rand_upper());
    prog[1] = make_instr(K_IMM, core_pkg::ALU_ADD, 2, 0, 0, rand_imm12());
    prog[2] = make_instr(K_LUI, core_pkg::ALU_ADD, 3, 0, 0, rand_upper());
    prog[3] = make_instr(K_IMM, core_pkg::ALU_ADD, 4, 1, 0, rand_imm12());
    for (i = SEED_LEN; i < PROG_LEN; i++) begin
      case (mode)
        0: prog[i] = random_alu_instr(rand_reg(), last_rd, prev_rd, 1'b0);
        1: begin
          if (rand_below(5) == 0) begin
            prog[i] = make_instr(K_LUI, core_pkg::ALU_ADD, rand_reg(), 0, 0, rand_upper());
          end else begin
            prog[i] = random_alu_instr(rand_reg(), last_rd, 0, 1'b1);
          end
        end
        2: begin
          // store, load of the same word, add that uses the load at once
          case ((i - SEED_LEN) % 3)
            0: begin
              word    = rand_below(DMEM_WORDS);
              prog[i] = mem_instr(K_STORE, rand_reg(), word);
            end
            1: begin
              load_rd = rand_reg();
              prog[i] = mem_instr(K_LOAD, load_rd, word);
            end
            default: begin
              prog[i] = make_instr(K_REG, core_pkg::ALU_ADD, rand_reg(), load_rd, rand_reg(), '0);
            end
          endcase
        end
        3: prog[i] = random_alu_instr(x0_or_reg(), x0_or_reg(), x0_or_reg(), rand_below(2) == 1);
        default: begin
          k = rand_below(5);
          if (k == 3 && last_word < 0) begin
            k = 4;
          end
          case (k)
            0: prog[i] = random_alu_instr(rand_below(9), rand_below(9), rand_below(9), 1'b0);
            1: prog[i] = random_alu_instr(rand_below(9), rand_below(9), 0, 1'b1);
            2: prog[i] = make_instr(K_LUI, core_pkg::ALU_ADD, rand_below(9), 0, 0, rand_upper());
            3: begin
              word = rand_below(DMEM_WORDS);
              if (!written[word]) begin
                word = last_word;
              end
              prog[i] = mem_instr(K_LOAD, rand_below(9), word);
            end
            default: prog[i] = mem_instr(K_STORE, rand_below(9), rand_below(DMEM_WORDS));
          endcase
        end
      endcase
      if (prog[i].kind != K_STORE) begin
        prev_rd = last_rd;
        last_rd = prog[i].rd;
      end
    end
  endfunction

  function automatic logic [2:0] funct3_of(input core_pkg::alu_op_e alu);
    case (alu)
      core_pkg::ALU_ADD, core_pkg::ALU_SUB: return 3'b000;
      core_pkg::ALU_SLL:                    return 3'b001;
      core_pkg::ALU_SLT:                    return 3'b010;
      core_pkg::ALU_SLTU:                   return 3'b011;
      core_pkg::ALU_XOR:                    return 3'b100;
      core_pkg::ALU_SRL, core_pkg::ALU_SRA: return 3'b101;
      core_pkg::ALU_OR:                     return 3'b110;
      default:                              return 3'b111;
    endcase
  endfunction

  function automatic logic [31:0] encode(input instr_t ins);
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [31:0] word;
    f7 = (ins.alu == core_pkg::ALU_SUB || ins.alu == core_pkg::ALU_SRA) ? 7'b0100000 : 7'b0;
    f3 = funct3_of(ins.alu);
    case (ins.kind)
      K_REG: word = {f7, ins.rs2, ins.rs1, f3, ins.rd, core_pkg::OPC_OP};
      K_IMM: begin
        if (f3 == 3'b001 || f3 == 3'b101) begin
          word = {f7, ins.imm[4:0], ins.rs1, f3, ins.rd, core_pkg::OPC_OP_IMM};
        end else begin
          word = {ins.imm[11:0], ins.rs1, f3, ins.rd, core_pkg::OPC_OP_IMM};
        end
      end
      K_LUI:   word = {ins.imm[31:12], ins.rd, core_pkg::OPC_LUI};
      K_LOAD:  word = {ins.imm[11:0], ins.rs1, 3'b010, ins.rd, core_pkg::OPC_LOAD};
      default: word = {ins.imm[11:5], ins.rs2, ins.rs1, 3'b010, ins.imm[4:0], core_pkg::OPC_STORE};
    endcase
    return word;
  endfunction

  // ==============================
  // reference model
  // ==============================
  function automatic logic [31:0] alu_ref(input core_pkg::alu_op_e alu,
                                          input logic [31:0] a, input logic [31:0] b);
    case (alu)
      core_pkg::ALU_ADD:  return a + b;
      core_pkg::ALU_SUB:  return a - b;
      core_pkg::ALU_AND:  return a & b;
      core_pkg::ALU_OR:   return a | b;
      core_pkg::ALU_XOR:  return a ^ b;
      core_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      core_pkg::ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      core_pkg::ALU_SLL:  return a << b[4:0];
      core_pkg::ALU_SRL:  return a >> b[4:0];
      default:            return $signed(a) >>> b[4:0];
    endcase
  endfunction

  // sequential run of the program, one record per write to a nonzero rd
  function automatic void run_reference();
    instr_t      ins;
    exp_t        rec;
    logic [31:0] val;
    logic [31:0] addr;
    int          i;
    for (i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    exp_q.delete();
    for (i = 0; i < PROG_LEN; i++) begin
      ins  = prog[i];
      addr = mregs[ins.rs1] + ins.imm;
      val  = '0;
      case (ins.kind)
        K_REG:   val = alu_ref(ins.alu, mregs[ins.rs1], mregs[ins.rs2]);
        K_IMM:   val = alu_ref(ins.alu, mregs[ins.rs1], ins.imm);
        K_LUI:   val = ins.imm;
        K_LOAD:  val = mdmem[addr[`DMEM_DEPTH_LOG2+1:2]];
        default: mdmem[addr[`DMEM_DEPTH_LOG2+1:2]] = mregs[ins.rs2];
      endcase
      if (ins.kind != K_STORE && ins.rd != '0) begin
        mregs[ins.rd] = val;
        rec.rd        = ins.rd;
        rec.data      = val;
        exp_q.push_back(rec);
      end
    end
  endfunction

  // ==============================
  // stimulus and comparison
  // ==============================
  task automatic next_drive_point();
    @(posedge clk);
    #0.5;
  endtask

  task automatic run_test(input int t);
    int i;
    next_drive_point();
    cur_test = t;
    rst_n_i  = 1'b0;
    run_i    = 1'b0;
    prog_i   = '0;
    generate_program(t);
    run_reference();
    repeat (RESET_CYCLES) next_drive_point();
    rst_n_i = 1'b1;
    for (i = 0; i < PROG_LEN; i++) begin
      prog_i.we   = 1'b1;
      prog_i.addr = i[`IMEM_DEPTH_LOG2-1:0];
      prog_i.inst = encode(prog[i]);
      next_drive_point();
    end
    prog_i     = '0;
    run_i      = 1'b1;
    run_cycles = 0;
    while (exp_q.size() != 0 && run_cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      run_cycles++;
    end
    assert (exp_q.size() == 0) else begin
      other_count++;
      timed_out = 1'b1;
      $display("timeout in test %s, %0d retirements missing after %0d cycles",
               test_name(t), exp_q.size(), run_cycles);
    end
    // late extra retirements show up here
    repeat (DRAIN_CYCLES) @(posedge clk);
  endtask

  always @(negedge clk) begin
    exp_t exp_rec;
    if (rst_n_i && retire_o.valid) begin
      assert (run_i) else begin
        other_count++;
        $display("retirement while the core was not running in test %s", test_name(cur_test));
      end
      assert (exp_q.size() != 0) else begin
        other_count++;
        $display("more retirements than expected in test %s", test_name(cur_test));
      end
      if (run_i && exp_q.size() != 0) begin
        exp_rec = exp_q.pop_front();
        assert (retire_o.rd == exp_rec.rd) else begin
          mismatch_count++;
          $display("mismatch %s rd expected x%0d actual x%0d",
                   test_name(cur_test), exp_rec.rd, retire_o.rd);
        end
        assert (retire_o.data == exp_rec.data) else begin
          mismatch_count++;
          $display("mismatch %s data of x%0d expected %h actual %h",
                   test_name(cur_test), exp_rec.rd, exp_rec.data, retire_o.data);
        end
      end
    end
  end

  initial begin
    int w;
    int t;
    rst_n_i        = 1'b0;
    run_i          = 1'b0;
    prog_i         = '0;
    seed           = 61827;
    cur_test       = 0;
    mismatch_count = 0;
    other_count    = 0;
    run_cycles     = 0;
    timed_out      = 1'b0;
    last_word      = -1;
    for (w = 0; w < DMEM_WORDS; w++) begin
      written[w] = 1'b0;
      mdmem[w]   = '0;
    end
    for (t = 0; t < NUM_TESTS && !timed_out; t++) begin
      run_test(t);
    end
    $display("error counts: %0d mismatches, %0d other failures", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+.
core_pkg.sv
pipe_reg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
core_top.sv
core_assert.sv
core_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module core_tb -f verilog.f \
  -Mdir obj_dir -o core_sim > build.log 2>&1 \
  && ./obj_dir/core_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
grep -q '^\*\*\* TEST PASSED \*\*\*$' sim.log \
  && { echo "simulation passed"; exit 0; } \
  || { cat sim.log; echo "simulation failed"; exit 1; }
